// ==== src/bus_hub_pkg.sv ====
// Shared memory map, I/O map and enum types for the CPU bus hub, imported by the RTL blocks

package bus_hub_pkg;

    // ==============================
    // Enums
    // ==============================

    // Memory region that a CPU address falls in
    typedef enum logic [1:0] {
        REG_ROM  = 2'd0,
        REG_BANK = 2'd1,
        REG_RAM  = 2'd2,
        REG_NONE = 2'd3
    } region_t;

    // SDRAM bridge FSM states
    typedef enum logic [1:0] {
        BR_IDLE = 2'd0,
        BR_REQ  = 2'd1,
        BR_WAIT = 2'd2,
        BR_DONE = 2'd3
    } bridge_state_t;

    // ==============================
    // Memory map
    // ==============================

    localparam logic [19:0] ROM_LIMIT     = 20'h80000;     // Linear ROM, read only
    localparam logic [19:0] BANK_BASE     = 20'hA0000;
    localparam logic [19:0] BANK_LIMIT    = 20'hBFFFF;     // Last address of the bank window
    localparam logic [24:0] BANK_SDR_BASE = 25'h0100000;   // 128 KB per bank above this

    // Work RAM is the only writable region
    localparam logic [19:0] RAM_BASE      = 20'hE0000;
    localparam logic [19:0] RAM_LIMIT     = 20'hEFFFF;
    localparam logic [24:0] RAM_SDR_BASE  = 25'h0400000;

    // ==============================
    // I/O map
    // ==============================

    localparam logic [7:0] IO_INPUTS = 8'h00;  // Player 1 and 2
    localparam logic [7:0] IO_FLAGS  = 8'h02;  // DIP high byte, coin, start; write loads sys_flags
    localparam logic [7:0] IO_DIPS   = 8'h04;
    localparam logic [7:0] IO_DEBUG  = 8'h06;
    localparam logic [7:0] IO_BANK   = 8'h20;  // ROM bank select, write only

    // Unmapped reads float high
    localparam logic [15:0] OPEN_BUS = 16'hFFFF;

endpackage

// ==== src/cpu_access_if.sv ====
// Start/done access channel from the bus controller to one target block (I/O or memory)

`timescale 1ns/100ps

interface cpu_access_if;

    logic        valid;     // One-cycle start pulse
    logic        write;
    logic [19:0] addr;      // Word aligned; I/O uses bits 7:0
    logic [15:0] wdata;     // Odd bytes already on the upper lane
    logic [1:0]  be;

    logic        done;      // One pulse per valid
    logic [15:0] rdata;     // Valid while done is high

    modport ctrl (
        output valid,
        output write,
        output addr,
        output wdata,
        output be,
        input  done,
        input  rdata
    );

    modport target (
        input  valid,
        input  write,
        input  addr,
        input  wdata,
        input  be,
        output done,
        output rdata
    );

endinterface

// ==== src/io_ports.sv ====
// I/O port block of the bus hub: input and DIP reads, flag and bank registers, debug latch

`timescale 1ns/100ps

module io_ports (
    input  logic        clk_sys,
    input  logic        reset_n,

    cpu_access_if.target bus,

    input  logic [7:0]  p1_input,       // Active high
    input  logic [7:0]  p2_input,
    input  logic [1:0]  coin,
    input  logic [1:0]  start_buttons,
    input  logic [23:0] dip_sw,

    input  logic        dbg_io_write,
    input  logic [7:0]  dbg_io_data,
    output logic        dbg_io_wait,

    output logic [7:0]  sys_flags,
    output logic [3:0]  bank_select
);

    import bus_hub_pkg::*;

    logic [7:0]  dbg_latch;
    logic [7:0]  port;
    logic [15:0] read_word;
    logic        rd_strobe;
    logic        wr_strobe;

    assign port      = bus.addr[7:0];
    assign rd_strobe = bus.valid & ~bus.write;
    assign wr_strobe = bus.valid & bus.write & bus.be[0];   // Registers live in the low byte

    // Board inputs are active low on the real bus
    always_comb begin
        case (port)
            IO_INPUTS: read_word = {~p2_input, ~p1_input};
            IO_FLAGS:  read_word = {~dip_sw[23:16], 4'hF, ~coin, ~start_buttons};
            IO_DIPS:   read_word = ~dip_sw[15:0];
            IO_DEBUG:  read_word = {dbg_latch, dbg_latch};
            default:   read_word = OPEN_BUS;
        endcase
    end

    // ==============================
    // Response, one cycle after valid
    // ==============================

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            bus.done <= 1'b0;
        end else begin
            bus.done <= bus.valid;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (bus.valid) bus.rdata <= read_word;
    end

    // ==============================
    // Writable registers
    // ==============================

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            sys_flags   <= 8'h00;
            bank_select <= 4'h0;
        end else if (wr_strobe) begin
            if (port == IO_FLAGS) sys_flags <= bus.wdata[7:0];
            if (port == IO_BANK) bank_select <= bus.wdata[3:0];
        end
    end

    // Debug latch: host write sets wait, CPU read of the port releases it
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            dbg_io_wait <= 1'b0;
            dbg_latch   <= 8'hFF;
        end else begin
            if (rd_strobe && port == IO_DEBUG) dbg_io_wait <= 1'b0;
            if (dbg_io_write) begin         // Host write wins over a same-cycle read
                dbg_io_wait <= 1'b1;
                dbg_latch   <= dbg_io_data;
            end
        end
    end

endmodule

// ==== src/sdram_bridge.sv ====
// Memory side of the bus hub: map decode, SDRAM address translation and one-at-a-time requests

`timescale 1ns/100ps

module sdram_bridge (
    input  logic        clk_sys,
    input  logic        reset_n,

    cpu_access_if.target bus,

    input  logic [3:0]  bank_select,

    output logic [24:0] sdr_addr,
    output logic [15:0] sdr_din,
    output logic [1:0]  sdr_wr_sel,     // Zero means read
    output logic        sdr_req_valid,
    input  logic        sdr_req_ready,
    input  logic        sdr_rsp_valid,
    input  logic [15:0] sdr_dout
);

    import bus_hub_pkg::*;

    bridge_state_t state;
    region_t       region;
    logic [24:0]   region_addr;
    logic [19:0]   bank_off;
    logic [19:0]   ram_off;

    assign bank_off = bus.addr - BANK_BASE;
    assign ram_off  = bus.addr - RAM_BASE;

    // ==============================
    // Address decode
    // ==============================

    always_comb begin
        if (bus.addr < ROM_LIMIT) begin
            region      = REG_ROM;
            region_addr = {5'd0, bus.addr};
        end else if (bus.addr >= BANK_BASE && bus.addr <= BANK_LIMIT) begin
            region      = REG_BANK;
            region_addr = BANK_SDR_BASE + {4'd0, bank_select, 17'd0} + {5'd0, bank_off};
        end else if (bus.addr >= RAM_BASE && bus.addr <= RAM_LIMIT) begin
            region      = REG_RAM;
            region_addr = RAM_SDR_BASE + {5'd0, ram_off};
        end else begin
            region      = REG_NONE;
            region_addr = 25'd0;
        end
    end

    // ==============================
    // Request FSM
    // ==============================

    assign sdr_req_valid = (state == BR_REQ);
    assign bus.done      = (state == BR_DONE);

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            state <= BR_IDLE;
        end else begin
            case (state)
                BR_IDLE: if (bus.valid) state <= (region == REG_NONE) ? BR_DONE : BR_REQ;
                BR_REQ: begin
                    if (sdr_req_ready) state <= sdr_rsp_valid ? BR_DONE : BR_WAIT;
                end
                BR_WAIT: if (sdr_rsp_valid) state <= BR_DONE;
                default: state <= BR_IDLE;   // BR_DONE lasts one cycle
            endcase
        end
    end

    // Payload is held from the start pulse until the SDRAM accepts it
    always_ff @(posedge clk_sys) begin
        if (state == BR_IDLE && bus.valid) begin
            sdr_addr   <= region_addr;
            sdr_din    <= bus.wdata;
            sdr_wr_sel <= (region == REG_RAM && bus.write) ? bus.be : 2'b00;
        end
    end

    // Read data, or open bus for an unmapped access
    always_ff @(posedge clk_sys) begin
        if (state == BR_IDLE && bus.valid) begin
            bus.rdata <= OPEN_BUS;
        end else if ((state == BR_WAIT || (state == BR_REQ && sdr_req_ready)) && sdr_rsp_valid) begin
            bus.rdata <= sdr_dout;
        end
    end

endmodule

// ==== src/cpu_bus_ctrl.sv ====
// CPU side of the bus hub: accepts one request, dispatches it to I/O or memory, returns the result

`timescale 1ns/100ps

module cpu_bus_ctrl (
    input  logic        clk_sys,
    input  logic        reset_n,

    input  logic        cpu_req_valid,
    output logic        cpu_req_ready,
    input  logic        cpu_req_io,
    input  logic        cpu_req_write,
    input  logic [19:0] cpu_addr,
    input  logic [15:0] cpu_wdata,
    input  logic [1:0]  cpu_be,
    output logic        cpu_rsp_valid,
    output logic [15:0] cpu_rdata,

    cpu_access_if.ctrl  io_bus,
    cpu_access_if.ctrl  mem_bus
);

    logic        busy;
    logic        odd;           // Byte offset of the access in flight
    logic        io_valid;
    logic        mem_valid;
    logic        write_q;
    logic [19:0] addr_q;
    logic [15:0] wdata_q;
    logic [1:0]  be_q;
    logic        accept;
    logic [15:0] rsp_word;

    assign accept        = cpu_req_valid & ~busy;
    assign cpu_req_ready = ~busy;

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            busy      <= 1'b0;
            odd       <= 1'b0;
            io_valid  <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            io_valid  <= 1'b0;
            mem_valid <= 1'b0;
            if (accept) begin
                busy      <= 1'b1;
                odd       <= cpu_addr[0];
                io_valid  <= cpu_req_io;
                mem_valid <= ~cpu_req_io;
            end else if (cpu_rsp_valid) begin
                busy <= 1'b0;
            end
        end
    end

    // Align the address and move an odd byte onto the upper lane
    always_ff @(posedge clk_sys) begin
        if (accept) begin
            write_q <= cpu_req_write;
            addr_q  <= {cpu_addr[19:1], 1'b0};
            wdata_q <= cpu_addr[0] ? {cpu_wdata[7:0], 8'h00} : cpu_wdata;
            be_q    <= cpu_addr[0] ? {cpu_be[0], 1'b0} : cpu_be;
        end
    end

    assign io_bus.valid  = io_valid;
    assign io_bus.write  = write_q;
    assign io_bus.addr   = addr_q;
    assign io_bus.wdata  = wdata_q;
    assign io_bus.be     = be_q;

    assign mem_bus.valid = mem_valid;
    assign mem_bus.write = write_q;
    assign mem_bus.addr  = addr_q;
    assign mem_bus.wdata = wdata_q;
    assign mem_bus.be    = be_q;

    // Only one target can be done at a time
    assign cpu_rsp_valid = io_bus.done | mem_bus.done;
    assign rsp_word      = io_bus.done ? io_bus.rdata : mem_bus.rdata;
    assign cpu_rdata     = odd ? {8'h00, rsp_word[15:8]} : rsp_word;

endmodule

// ==== src/bus_hub.sv ====
// Top level of the CPU bus hub, joining the bus controller, I/O ports and SDRAM bridge

`timescale 1ns/100ps

module bus_hub (
    input  logic        clk_sys,
    input  logic        reset_n,

    // CPU request and response
    input  logic        cpu_req_valid,
    output logic        cpu_req_ready,
    input  logic        cpu_req_io,
    input  logic        cpu_req_write,
    input  logic [19:0] cpu_addr,
    input  logic [15:0] cpu_wdata,
    input  logic [1:0]  cpu_be,
    output logic        cpu_rsp_valid,
    output logic [15:0] cpu_rdata,

    // Board inputs
    input  logic [7:0]  p1_input,
    input  logic [7:0]  p2_input,
    input  logic [1:0]  coin,
    input  logic [1:0]  start_buttons,
    input  logic [23:0] dip_sw,

    input  logic        dbg_io_write,
    input  logic [7:0]  dbg_io_data,
    output logic        dbg_io_wait,

    output logic [7:0]  sys_flags,
    output logic [3:0]  bank_select,

    // SDRAM port
    output logic [24:0] sdr_addr,
    output logic [15:0] sdr_din,
    output logic [1:0]  sdr_wr_sel,
    output logic        sdr_req_valid,
    input  logic        sdr_req_ready,
    input  logic        sdr_rsp_valid,
    input  logic [15:0] sdr_dout
);

    cpu_access_if io_bus ();
    cpu_access_if mem_bus ();

    cpu_bus_ctrl u_ctrl (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_ready (cpu_req_ready),
        .cpu_req_io    (cpu_req_io),
        .cpu_req_write (cpu_req_write),
        .cpu_addr      (cpu_addr),
        .cpu_wdata     (cpu_wdata),
        .cpu_be        (cpu_be),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rdata     (cpu_rdata),
        .io_bus        (io_bus.ctrl),
        .mem_bus       (mem_bus.ctrl)
    );

    io_ports u_io (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .bus           (io_bus.target),
        .p1_input      (p1_input),
        .p2_input      (p2_input),
        .coin          (coin),
        .start_buttons (start_buttons),
        .dip_sw        (dip_sw),
        .dbg_io_write  (dbg_io_write),
        .dbg_io_data   (dbg_io_data),
        .dbg_io_wait   (dbg_io_wait),
        .sys_flags     (sys_flags),
        .bank_select   (bank_select)
    );

    sdram_bridge u_mem (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .bus           (mem_bus.target),
        .bank_select   (bank_select),       // Bank register feeds the ROM window
        .sdr_addr      (sdr_addr),
        .sdr_din       (sdr_din),
        .sdr_wr_sel    (sdr_wr_sel),
        .sdr_req_valid (sdr_req_valid),
        .sdr_req_ready (sdr_req_ready),
        .sdr_rsp_valid (sdr_rsp_valid),
        .sdr_dout      (sdr_dout)
    );

endmodule

// ==== test/bus_hub_tb.sv ====
// Testbench for the CPU bus hub with an SDRAM model, directed and random accesses and concurrent checks

`timescale 1ns/100ps

module bus_hub_tb;

    import bus_hub_pkg::*;

    localparam int STRESS_COUNT  = 30;
    localparam int ACCESS_COUNT  = 25 + STRESS_COUNT;  // Upper bound on CPU accesses
    localparam int ACCESS_CYCLES = 16;      // 3 stalls, 5 latency, handshake and task overhead

    logic        clk_sys = 1'b0;
    logic        reset_n;
    logic        cpu_req_valid, cpu_req_ready, cpu_req_io, cpu_req_write;
    logic [19:0] cpu_addr;
    logic [15:0] cpu_wdata, cpu_rdata;
    logic [1:0]  cpu_be;
    logic        cpu_rsp_valid;
    logic [7:0]  p1_input, p2_input, dbg_io_data, sys_flags;
    logic [1:0]  coin, start_buttons;
    logic [23:0] dip_sw;
    logic        dbg_io_write, dbg_io_wait;
    logic [3:0]  bank_select;
    logic [24:0] sdr_addr;
    logic [15:0] sdr_din, sdr_dout;
    logic [1:0]  sdr_wr_sel;
    logic        sdr_req_valid, sdr_req_ready, sdr_rsp_valid;

    int          seed = 80614;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed = 0;
    int          valid_cycles = 0;  // Cycles with sdr_req_valid high
    logic [24:0] last_addr;         // Last request taken by the SDRAM model
    logic [15:0] last_din;
    logic [1:0]  last_sel;
    logic [15:0] sdr_mem [logic [24:0]];
    logic        outstanding;
    logic        cpu_accept;

    bus_hub u_dut (.*);

    always #50 clk_sys = ~clk_sys;

    // ==============================
    // SDRAM model
    // ==============================

    // Unwritten words read back as a mix of all address bits
    function automatic logic [15:0] fill_word(input logic [24:0] a);
        return a[15:0] ^ {7'h35, a[24:16]};
    endfunction

    function automatic logic [15:0] model_word(input logic [24:0] a);
        if (sdr_mem.exists(a)) return sdr_mem[a];
        return fill_word(a);
    endfunction

    initial begin : sdram_model
        int          rnd;
        int          wait_left;
        int          stall_cnt;
        logic [15:0] word;
        sdr_req_ready = 1'b0;
        sdr_rsp_valid = 1'b0;
        sdr_dout      = 16'h0000;
        wait_left     = 0;
        stall_cnt     = 0;
        forever begin
            @(posedge clk_sys);
            #10;
            sdr_rsp_valid = 1'b0;
            rnd = $random(seed);
            sdr_req_ready = rnd[0] | (stall_cnt >= 3);  // Never more than 3 stalls in a row
            stall_cnt = sdr_req_ready ? 0 : stall_cnt + 1;
            if (sdr_req_valid) valid_cycles++;
            if (wait_left > 0) begin
                wait_left--;
                if (wait_left == 0) sdr_rsp_valid = 1'b1;
            end else if (sdr_req_valid && sdr_req_ready) begin
                word = model_word(sdr_addr);
                if (sdr_wr_sel[0]) word[7:0] = sdr_din[7:0];
                if (sdr_wr_sel[1]) word[15:8] = sdr_din[15:8];
                if (sdr_wr_sel != 2'b00) sdr_mem[sdr_addr] = word;
                sdr_dout  = word;
                last_addr = sdr_addr;
                last_din  = sdr_din;
                last_sel  = sdr_wr_sel;
                rnd = $random(seed);
                wait_left = (rnd & 32'h7fff_ffff) % 6;
                if (wait_left == 0) sdr_rsp_valid = 1'b1;    // Same-cycle answer
            end
        end
    end

    // ==============================
    // Concurrent checks
    // ==============================

    assign cpu_accept = cpu_req_valid & cpu_req_ready;

    always @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) outstanding <= 1'b0;
        else if (cpu_accept) outstanding <= 1'b1;
        else if (cpu_rsp_valid) outstanding <= 1'b0;
    end

    sdr_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
        sdr_req_valid && !sdr_req_ready |=> sdr_req_valid && $stable(sdr_addr)
            && $stable(sdr_din) && $stable(sdr_wr_sel))
        else begin
            errors++;
            $display("SDRAM request changed while ready was low at %0t", $time);
        end

    io_latency: assert property (@(posedge clk_sys) disable iff (!reset_n)
        $past(cpu_accept && cpu_req_io, 2) |-> cpu_rsp_valid)
        else begin
            errors++;
            $display("I/O response missing 2 cycles after acceptance at %0t", $time);
        end

    mem_latency: assert property (@(posedge clk_sys) disable iff (!reset_n)
        $past(sdr_rsp_valid) |-> cpu_rsp_valid)
        else begin
            errors++;
            $display("No CPU response 1 cycle after SDRAM response at %0t", $time);
        end

    busy_ready: assert property (@(posedge clk_sys) disable iff (!reset_n)
        outstanding |-> !cpu_req_ready)
        else begin
            errors++;
            $display("CPU request ready while an access is outstanding at %0t", $time);
        end

    single_rsp: assert property (@(posedge clk_sys) disable iff (!reset_n)
        cpu_rsp_valid |-> outstanding)
        else begin
            errors++;
            $display("CPU response without an outstanding request at %0t", $time);
        end

    initial begin : watchdog
        #((5 + ACCESS_COUNT * ACCESS_CYCLES + 50) * 100);
        $display("Timeout: the run did not finish in the expected time");
        $display("Errors found");
        $finish;
    end

    // ==============================
    // CPU side tasks
    // ==============================

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Starts and ends 10 ns after a rising edge
    task automatic cpu_access(input logic io, input logic wr, input logic [19:0] addr,
                              input logic [15:0] wdata, input logic [1:0] be,
                              output logic [15:0] rdata);
        while (!cpu_req_ready) begin
            @(posedge clk_sys);
            #10;
        end
        cpu_req_valid = 1'b1;
        cpu_req_io    = io;
        cpu_req_write = wr;
        cpu_addr      = addr;
        cpu_wdata     = wdata;
        cpu_be        = be;
        @(posedge clk_sys);
        #10;
        cpu_req_valid = 1'b0;
        do @(negedge clk_sys); while (!cpu_rsp_valid);
        rdata = cpu_rdata;
        @(posedge clk_sys);
        #10;
    endtask

    task automatic cpu_read(input logic io, input logic [19:0] addr, output logic [15:0] rd);
        cpu_access(io, 1'b0, addr, 16'h0000, 2'b11, rd);
    endtask

    task automatic cpu_write(input logic io, input logic [19:0] addr, input logic [15:0] data,
                             input logic [1:0] be);
        logic [15:0] unused_rd;
        cpu_access(io, 1'b1, addr, data, be, unused_rd);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("Test %s: passed", name);
        end else begin
            failed++;
            $display("Test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // ==============================
    // Tests
    // ==============================

    initial begin : stimulus
        logic [15:0] rd;
        logic [19:0] addr;
        logic [15:0] ram_ref [16];
        int          mark;
        int          rnd;
        int          i;
        reset_n       = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req_io    = 1'b0;
        cpu_req_write = 1'b0;
        cpu_addr      = 20'h00000;
        cpu_wdata     = 16'h0000;
        cpu_be        = 2'b00;
        p1_input      = 8'h12;
        p2_input      = 8'h34;
        coin          = 2'b01;
        start_buttons = 2'b10;
        dip_sw        = 24'hA5C33C;
        dbg_io_write  = 1'b0;
        dbg_io_data   = 8'h00;
        repeat (5) @(posedge clk_sys);
        #10;
        reset_n = 1'b1;
        check_value("cpu_req_ready", 32'(cpu_req_ready), 32'h1);
        check_value("cpu_rsp_valid", 32'(cpu_rsp_valid), 32'h0);
        check_value("sdr_req_valid", 32'(sdr_req_valid), 32'h0);
        check_value("dbg_io_wait", 32'(dbg_io_wait), 32'h0);
        check_value("sys_flags", 32'(sys_flags), 32'h0);
        check_value("bank_select", 32'(bank_select), 32'h0);

        // Board inputs read back inverted
        mark = errors;
        cpu_read(1'b1, 20'h00000, rd);
        check_value("cpu_rdata", 32'(rd), 32'hCBED);
        cpu_read(1'b1, 20'h00002, rd);
        check_value("cpu_rdata", 32'(rd), 32'h5AF9);    // ~DIP high, F, ~coin, ~start
        cpu_read(1'b1, 20'h00004, rd);
        check_value("cpu_rdata", 32'(rd), 32'h3CC3);
        cpu_read(1'b1, 20'h00008, rd);
        check_value("cpu_rdata", 32'(rd), 32'hFFFF);
        cpu_read(1'b1, 20'h00003, rd);                  // Odd port gives upper byte
        check_value("cpu_rdata", 32'(rd), 32'h005A);
        report_test("io_reads", mark);

        mark = errors;
        cpu_write(1'b1, 20'h00002, 16'h005A, 2'b11);
        check_value("sys_flags", 32'(sys_flags), 32'h5A);
        cpu_write(1'b1, 20'h00020, 16'h0003, 2'b01);
        check_value("bank_select", 32'(bank_select), 32'h3);
        dbg_io_write = 1'b1;
        dbg_io_data  = 8'h7E;
        @(posedge clk_sys);
        #10;
        dbg_io_write = 1'b0;
        check_value("dbg_io_wait", 32'(dbg_io_wait), 32'h1);
        cpu_read(1'b1, 20'h00006, rd);
        check_value("cpu_rdata", 32'(rd), 32'h7E7E);
        check_value("dbg_io_wait", 32'(dbg_io_wait), 32'h0);
        report_test("flag_bank_debug", mark);

        mark = errors;
        cpu_read(1'b0, 20'h12346, rd);
        check_value("sdr_addr", 32'(last_addr), 32'h0012346);
        check_value("sdr_wr_sel", 32'(last_sel), 32'h0);
        check_value("cpu_rdata", 32'(rd), 32'(fill_word(25'h0012346)));
        cpu_read(1'b0, 20'h12347, rd);
        check_value("sdr_addr", 32'(last_addr), 32'h0012346);
        check_value("cpu_rdata", 32'(rd), 32'({8'h00, fill_word(25'h0012346)}) >> 8);
        cpu_read(1'b0, 20'hA0124, rd);                  // Bank 3 sits at 0x100000 + 3 * 0x20000
        check_value("sdr_addr", 32'(last_addr), 32'h0160124);
        check_value("sdr_wr_sel", 32'(last_sel), 32'h0);
        check_value("cpu_rdata", 32'(rd), 32'(fill_word(25'h0160124)));
        report_test("rom_reads", mark);

        mark = errors;
        cpu_write(1'b0, 20'hE0010, 16'h1234, 2'b11);
        check_value("sdr_addr", 32'(last_addr), 32'h0400010);
        check_value("sdr_din", 32'(last_din), 32'h1234);
        check_value("sdr_wr_sel", 32'(last_sel), 32'h3);
        cpu_write(1'b0, 20'hE0011, 16'h00AB, 2'b01);   // Odd byte moves to the upper lane
        check_value("sdr_addr", 32'(last_addr), 32'h0400010);
        check_value("sdr_din", 32'(last_din), 32'hAB00);
        check_value("sdr_wr_sel", 32'(last_sel), 32'h2);
        cpu_write(1'b0, 20'hE0012, 16'h0055, 2'b01);
        check_value("sdr_din", 32'(last_din), 32'h0055);
        check_value("sdr_wr_sel", 32'(last_sel), 32'h1);
        cpu_read(1'b0, 20'hE0010, rd);
        check_value("cpu_rdata", 32'(rd), 32'hAB34);
        cpu_read(1'b0, 20'hE0012, rd);
        check_value("cpu_rdata", 32'(rd), 32'({fill_word(25'h0400012) >> 8, 8'h55}));
        cpu_read(1'b0, 20'hE0011, rd);
        check_value("cpu_rdata", 32'(rd), 32'h00AB);
        cpu_write(1'b0, 20'h00100, 16'hBEEF, 2'b11);   // ROM stays read only
        check_value("sdr_addr", 32'(last_addr), 32'h0000100);
        check_value("sdr_wr_sel", 32'(last_sel), 32'h0);
        cpu_read(1'b0, 20'h00100, rd);
        check_value("cpu_rdata", 32'(rd), 32'(fill_word(25'h0000100)));
        report_test("ram_writes", mark);

        mark = errors;
        i = valid_cycles;
        cpu_read(1'b0, 20'hC0000, rd);
        check_value("cpu_rdata", 32'(rd), 32'hFFFF);
        cpu_write(1'b0, 20'h90000, 16'h1111, 2'b11);
        cpu_read(1'b0, 20'hF8000, rd);
        check_value("cpu_rdata", 32'(rd), 32'hFFFF);
        if (valid_cycles != i) begin
            errors++;
            $display("Unmapped access raised an SDRAM request");
        end
        report_test("unmapped", mark);

        // Expected contents of the stress words, untouched so far
        for (i = 0; i < 16; i++) begin
            ram_ref[i] = fill_word(25'h0400100 + 25'(2 * i));
        end

        // Random RAM traffic on a few words, under random ready stalls
        mark = errors;
        for (i = 0; i < STRESS_COUNT; i++) begin
            rnd  = $random(seed);
            addr = 20'hE0100 + {15'd0, rnd[4:1], 1'b0};
            if (rnd[16]) begin
                cpu_write(1'b0, addr, rnd[31:16], 2'b11);
                ram_ref[rnd[4:1]] = rnd[31:16];
            end else begin
                cpu_read(1'b0, addr, rd);
                check_value("cpu_rdata", 32'(rd), 32'(ram_ref[rnd[4:1]]));
            end
        end
        report_test("backpressure", mark);

        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== bus_hub.f ====
src/bus_hub_pkg.sv
src/cpu_access_if.sv
src/io_ports.sv
src/sdram_bridge.sv
src/cpu_bus_ctrl.sv
src/bus_hub.sv
test/bus_hub_tb.sv

// ==== Makefile ====
TOP := bus_hub_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f bus_hub.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing -f bus_hub.f --top-module $(TOP)

clean:
	rm -rf obj_dir
